/* busMachine_config.svh */
`ifndef BUS_MACHINE_CONFIG_SVH
`define BUS_MACHINE_CONFIG_SVH

// number of general registers, 2 to 4
// register fields in the microword are 2 bits wide
`define REG_COUNT 4

// data word width
`define WORD_WIDTH 8

`endif

/* busMachinePkg.sv */
package busMachinePkg;

  // alu operation codes, as carried in the transfer form
  typedef enum logic [2:0] {
    ADD   = 3'd0,
    SUB   = 3'd1,
    AND   = 3'd2,
    OR    = 3'd3,
    XOR   = 3'd4,
    PASSB = 3'd5,
    SHL   = 3'd6,
    NOTA  = 3'd7
  } aluOp;

  // register transfer microinstruction, format bit 0
  // source 0-3 register, 4 alu, 5 immediate (zero here), 6-7 nothing
  typedef struct packed {
    logic       formatBit;
    logic [2:0] aluOp;
    logic [2:0] source;
    logic [1:0] dest;
    logic       writeEnable;
    logic       incrementDest;
    logic       clearDest;
    logic [1:0] aluB;
    logic [1:0] spare;
  } transferForm;

  // load immediate microinstruction, format bit 1
  typedef struct packed {
    logic       formatBit;
    logic [4:0] spare;
    logic [1:0] dest;
    logic [7:0] immediate;
  } immediateForm;

  // one 16-bit word, two decodings picked by the top bit
  typedef union packed {
    transferForm  transfer;
    immediateForm immediateLoad;
  } microWord;

  // per-register strobes
  typedef struct packed {
    logic load;
    logic increment;
    logic clear;
  } regControl;

  // status kept after alu writes
  typedef struct packed {
    logic zero;
    logic carry;
  } aluFlags;

endpackage

/* internalBus.sv */
// one-hot selected bus, input 0 when nothing is selected
module internalBus #(
  parameter int INPUT_COUNT = 2,
  parameter int WIDTH       = 8
) (
  input  logic [INPUT_COUNT-1:0]       busSelect,
  input  logic [WIDTH*INPUT_COUNT-1:0] busInputs,
  output logic [WIDTH-1:0]             busOutput
);

  // encoded select width, at least one bit
  localparam int SELECT_WIDTH = (INPUT_COUNT > 1) ? $clog2(INPUT_COUNT) : 1;

  logic [SELECT_WIDTH-1:0] selectIndex;
  logic [WIDTH-1:0]        inputWords [INPUT_COUNT];

  // one-hot to index over every input position
  always_comb begin
    selectIndex = '0;
    for (int i = 0; i < INPUT_COUNT; i++) begin
      if (busSelect[i]) begin
        selectIndex = i[SELECT_WIDTH-1:0];
      end
    end
  end

  // split the packed inputs into words
  for (genvar i = 0; i < INPUT_COUNT; i++) begin : gUnpack
    assign inputWords[i] = busInputs[WIDTH*i +: WIDTH];
  end

  assign busOutput = inputWords[selectIndex];

  // more than one driver would be a decode fault upstream
  always_comb begin
    assert ($onehot0(busSelect)) else $error("internalBus: busSelect not one-hot");
  end

endmodule

/* dataRegister.sv */
`include "busMachine_config.svh"

module dataRegister (
  input  logic                     clk,
  input  logic                     reset,
  input  busMachinePkg::regControl control,
  input  logic [`WORD_WIDTH-1:0]   loadData,
  output logic [`WORD_WIDTH-1:0]   value
);

  // clear, then load, then increment
  always_ff @(posedge clk) begin
    if (reset) begin
      value <= '0;
    end else if (control.clear) begin
      value <= '0;
    end else if (control.load) begin
      // bus value
      value <= loadData;
    end else if (control.increment) begin
      // wraps at the top
      value <= value + 1'b1;
    end
  end

  // decoder drops increment whenever it writes back
  assert property (@(posedge clk) disable iff (reset)
    !(control.load && control.increment))
    else $error("dataRegister: load and increment together");

endmodule

/* aluUnit.sv */
`include "busMachine_config.svh"

module aluUnit (
  input  logic                   clk,
  input  logic                   reset,
  input  busMachinePkg::aluOp    operation,
  input  logic [`WORD_WIDTH-1:0] operandA,
  input  logic [`WORD_WIDTH-1:0] operandB,
  input  logic                   flagUpdate,
  output logic [`WORD_WIDTH-1:0] result,
  output busMachinePkg::aluFlags flags
);

  // extra top bit holds carry, borrow or shifted-out bit
  logic [`WORD_WIDTH:0] wideResult;

  always_comb begin
    wideResult = '0;
    case (operation)
      busMachinePkg::ADD:   wideResult = {1'b0, operandA} + {1'b0, operandB};
      // top bit set when a is below b
      busMachinePkg::SUB:   wideResult = {1'b0, operandA} - {1'b0, operandB};
      busMachinePkg::AND:   wideResult = {1'b0, operandA & operandB};
      busMachinePkg::OR:    wideResult = {1'b0, operandA | operandB};
      busMachinePkg::XOR:   wideResult = {1'b0, operandA ^ operandB};
      busMachinePkg::PASSB: wideResult = {1'b0, operandB};
      // accumulator msb lands in the carry position
      busMachinePkg::SHL:   wideResult = {operandA, 1'b0};
      busMachinePkg::NOTA:  wideResult = {1'b0, ~operandA};
      default:              wideResult = '0;
    endcase
  end

  // result goes straight to the bus
  assign result = wideResult[`WORD_WIDTH-1:0];

  // flags only on a written alu result
  always_ff @(posedge clk) begin
    if (reset) begin
      flags <= '0;
    end else if (flagUpdate) begin
      flags.zero  <= (result == '0);
      flags.carry <= wideResult[`WORD_WIDTH];
    end
  end

endmodule

/* microDecoder.sv */
`include "busMachine_config.svh"

module microDecoder (
  input  logic                                         microValid,
  input  busMachinePkg::microWord                      microIn,
  output logic [`REG_COUNT+1:0]                        busSelect,
  output busMachinePkg::regControl [`REG_COUNT-1:0]    regControls,
  output busMachinePkg::aluOp                          aluOperation,
  output logic [1:0]                                   aluBSelect,
  output logic [`WORD_WIDTH-1:0]                       immediateValue,
  output logic                                         flagUpdate
);

  // bus slots after the registers
  localparam int ALU_INDEX = `REG_COUNT;
  localparam int IMM_INDEX = `REG_COUNT + 1;

  logic       isImmediate;
  logic [2:0] source;
  logic [1:0] dest;
  logic       sourceValid;
  logic       writeBack;

  // bus source and destination
  always_comb begin
    // format bit sits at the top in both forms
    isImmediate = microIn.transfer.formatBit;
    source      = microIn.transfer.source;
    dest        = isImmediate ? microIn.immediateLoad.dest : microIn.transfer.dest;
    busSelect   = '0;
    if (microValid) begin
      if (isImmediate) begin
        busSelect[IMM_INDEX] = 1'b1;
      end else if (source == 3'd4) begin
        busSelect[ALU_INDEX] = 1'b1;
      end else if (source == 3'd5) begin
        busSelect[IMM_INDEX] = 1'b1;
      end else if (int'(source) < `REG_COUNT) begin
        busSelect[source[1:0]] = 1'b1;
      end
      // 6 and 7 leave the bus unselected
    end
    sourceValid = |busSelect;
    // immediate form always writes
    writeBack   = sourceValid && (isImmediate || microIn.transfer.writeEnable);
  end

  // strobes only for the destination register
  always_comb begin
    regControls = '0;
    for (int i = 0; i < `REG_COUNT; i++) begin
      if (sourceValid && int'(dest) == i) begin
        regControls[i].load      = writeBack;
        // a write takes the place of an increment
        regControls[i].increment = !isImmediate && microIn.transfer.incrementDest && !writeBack;
        regControls[i].clear     = !isImmediate && microIn.transfer.clearDest;
      end
    end
  end

  // immediate byte is zero in transfer form
  assign immediateValue = isImmediate ? microIn.immediateLoad.immediate : '0;
  assign aluOperation   = busMachinePkg::aluOp'(microIn.transfer.aluOp);
  assign aluBSelect     = microIn.transfer.aluB;
  // flags follow only alu results that get written back
  assign flagUpdate     = microValid && !isImmediate && source == 3'd4 &&
                          microIn.transfer.writeEnable;

endmodule

/* busMachine.sv */
`include "busMachine_config.svh"

module busMachine (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     microValid,
  input  busMachinePkg::microWord  microIn,
  output logic [`WORD_WIDTH-1:0]   busValue,
  output busMachinePkg::aluFlags   flags
);

  // registers, then alu, then immediate
  localparam int BUS_INPUTS = `REG_COUNT + 2;

  busMachinePkg::regControl [`REG_COUNT-1:0] regControls;
  logic [BUS_INPUTS-1:0]                     busSelect;
  busMachinePkg::aluOp                       aluOperation;
  logic [1:0]                                aluBSelect;
  logic [`WORD_WIDTH-1:0]                    immediateValue;
  logic                                      flagUpdate;
  logic [`WORD_WIDTH-1:0]                    aluResult;
  logic [`WORD_WIDTH-1:0]                    operandB;
  logic [`WORD_WIDTH-1:0]                    regValues [`REG_COUNT];
  logic [`WORD_WIDTH*BUS_INPUTS-1:0]         busInputs;

  microDecoder microDecoder_i (
    .microValid     (microValid),
    .microIn        (microIn),
    .busSelect      (busSelect),
    .regControls    (regControls),
    .aluOperation   (aluOperation),
    .aluBSelect     (aluBSelect),
    .immediateValue (immediateValue),
    .flagUpdate     (flagUpdate)
  );

  // general registers, all loaded from the bus
  for (genvar i = 0; i < `REG_COUNT; i++) begin : gRegs
    dataRegister dataRegister_i (
      .clk      (clk),
      .reset    (reset),
      .control  (regControls[i]),
      .loadData (busValue),
      .value    (regValues[i])
    );
  end

  // operand b, zero for a register that does not exist
  always_comb begin
    operandB = '0;
    if (int'(aluBSelect) < `REG_COUNT) begin
      operandB = regValues[aluBSelect];
    end
  end

  // operand a is always the accumulator
  aluUnit aluUnit_i (
    .clk        (clk),
    .reset      (reset),
    .operation  (aluOperation),
    .operandA   (regValues[0]),
    .operandB   (operandB),
    .flagUpdate (flagUpdate),
    .result     (aluResult),
    .flags      (flags)
  );

  // pack bus sources in select order
  always_comb begin
    for (int i = 0; i < `REG_COUNT; i++) begin
      busInputs[`WORD_WIDTH*i +: `WORD_WIDTH] = regValues[i];
    end
    busInputs[`WORD_WIDTH*`REG_COUNT +: `WORD_WIDTH]     = aluResult;
    busInputs[`WORD_WIDTH*(`REG_COUNT+1) +: `WORD_WIDTH] = immediateValue;
  end

  internalBus #(
    .INPUT_COUNT (BUS_INPUTS),
    .WIDTH       (`WORD_WIDTH)
  ) internalBus_i (
    .busSelect (busSelect),
    .busInputs (busInputs),
    .busOutput (busValue)
  );

endmodule

/* tb_busMachine.sv */
module tb_busMachine;

  // one table row: stimulus, then expected bus and flags {zero, carry}
  typedef struct packed {
    logic        valid;
    logic [15:0] word;
    logic [7:0]  bus;
    logic [1:0]  flags;
  } tableRow;

  logic                    clk;
  logic                    reset;
  logic                    microValid;
  busMachinePkg::microWord microIn;
  logic [7:0]              busValue;
  busMachinePkg::aluFlags  flags;

  tableRow     rows[$];
  logic [31:0] lfsr;
  logic [7:0]  model [4];
  logic [1:0]  modelFlags;

  busMachine busMachine_i (
    .clk        (clk),
    .reset      (reset),
    .microValid (microValid),
    .microIn    (microIn),
    .busValue   (busValue),
    .flags      (flags)
  );

  always #10 clk = ~clk;

  task automatic failRun();
    $display("FAIL: see errors above");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic checkValue(input string name, input logic [15:0] actual,
                            input logic [15:0] expected);
    if (actual !== expected) begin
      $display("FAILED %s: got %h expected %h at %0t", name, actual, expected, $time);
      failRun();
    end
  endtask

  // poll the clock level in unit steps
  task automatic waitClock(input logic level);
    int steps;
    for (steps = 0; clk !== level && steps < 40; steps++) begin
      #1;
    end
    if (clk !== level) begin
      $display("clock did not reach level %b within 40 time units", level);
      failRun();
    end
  endtask

  // galois form, taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] nextLfsr(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
  endfunction

  // one lfsr step per bit taken
  function automatic logic [15:0] takeBits(input int count);
    logic [15:0] bits;
    bits = '0;
    for (int i = 0; i < count; i++) begin
      bits = {bits[14:0], lfsr[0]};
      lfsr = nextLfsr(lfsr);
    end
    return bits;
  endfunction

  function automatic logic [15:0] immWord(input logic [1:0] dest, input logic [7:0] value);
    return {1'b1, 5'b00000, dest, value};
  endfunction

  // writeIncClear holds write enable, increment and clear in that order
  function automatic logic [15:0] transferWord(input logic [2:0] op, input logic [2:0] src,
      input logic [1:0] dest, input logic [2:0] writeIncClear, input logic [1:0] aluB);
    return {1'b0, op, src, dest, writeIncClear, aluB, 2'b00};
  endfunction

  // register onto the bus, nothing written
  function automatic logic [15:0] readWord(input logic [2:0] src);
    return transferWord(3'd0, src, 2'd0, 3'b000, 2'd0);
  endfunction

  // alu result written to dest with flag update
  function automatic logic [15:0] aluWord(input logic [2:0] op, input logic [1:0] dest,
                                          input logic [1:0] aluB);
    return transferWord(op, 3'd4, dest, 3'b100, aluB);
  endfunction

  function automatic void addRow(input logic valid, input logic [15:0] word,
                                 input logic [7:0] bus, input logic [1:0] flagsOut);
    rows.push_back({valid, word, bus, flagsOut});
  endfunction

  task automatic buildTable();
    // idle after reset, then every register reads zero
    addRow(1'b0, 16'h0000, 8'h00, 2'b00);
    for (int r = 0; r < 4; r++) begin
      addRow(1'b1, readWord(r[2:0]), 8'h00, 2'b00);
    end
    // immediate loads, then read back
    addRow(1'b1, immWord(2'd0, 8'hC8), 8'hC8, 2'b00);
    addRow(1'b1, immWord(2'd1, 8'h5A), 8'h5A, 2'b00);
    addRow(1'b1, immWord(2'd2, 8'hC8), 8'hC8, 2'b00);
    addRow(1'b1, immWord(2'd3, 8'h80), 8'h80, 2'b00);
    addRow(1'b1, readWord(3'd0), 8'hC8, 2'b00);
    addRow(1'b1, readWord(3'd1), 8'h5A, 2'b00);
    addRow(1'b1, readWord(3'd2), 8'hC8, 2'b00);
    addRow(1'b1, readWord(3'd3), 8'h80, 2'b00);
    // c8 + c8 overflows into carry
    addRow(1'b1, aluWord(busMachinePkg::ADD, 2'd1, 2'd2), 8'h90, 2'b01);
    addRow(1'b1, readWord(3'd1), 8'h90, 2'b01);
    // equal operands give zero
    addRow(1'b1, aluWord(busMachinePkg::SUB, 2'd2, 2'd0), 8'h00, 2'b10);
    addRow(1'b1, readWord(3'd2), 8'h00, 2'b10);
    // top bit of c8 shifts into carry
    addRow(1'b1, aluWord(busMachinePkg::SHL, 2'd0, 2'd0), 8'h90, 2'b01);
    addRow(1'b1, readWord(3'd0), 8'h90, 2'b01);
    // clear wins over load and increment
    addRow(1'b1, transferWord(3'd0, 3'd3, 2'd1, 3'b111, 2'd0), 8'h80, 2'b01);
    addRow(1'b1, readWord(3'd1), 8'h00, 2'b01);
    addRow(1'b1, transferWord(3'd0, 3'd0, 2'd3, 3'b011, 2'd0), 8'h90, 2'b01);
    addRow(1'b1, readWord(3'd3), 8'h00, 2'b01);
    // ff increments to 00
    addRow(1'b1, immWord(2'd2, 8'hFF), 8'hFF, 2'b01);
    addRow(1'b1, transferWord(3'd0, 3'd2, 2'd2, 3'b010, 2'd0), 8'hFF, 2'b01);
    addRow(1'b1, readWord(3'd2), 8'h00, 2'b01);
    addRow(1'b1, readWord(3'd0), 8'h90, 2'b01);
    // idle or empty source, bus rests on r0 and nothing moves
    addRow(1'b0, immWord(2'd0, 8'h55), 8'h90, 2'b01);
    addRow(1'b0, aluWord(busMachinePkg::SUB, 2'd0, 2'd0), 8'h90, 2'b01);
    addRow(1'b1, transferWord(3'd1, 3'd6, 2'd0, 3'b101, 2'd0), 8'h90, 2'b01);
    addRow(1'b1, transferWord(3'd0, 3'd7, 2'd1, 3'b110, 2'd0), 8'h90, 2'b01);
    addRow(1'b1, readWord(3'd0), 8'h90, 2'b01);
    addRow(1'b1, readWord(3'd1), 8'h00, 2'b01);
  endtask

  // reference model, bus before the edge and flags after it
  task automatic modelStep(input logic valid, input logic [15:0] word,
                           output logic [7:0] expBus, output logic [1:0] expFlags);
    logic [2:0] src;
    logic [1:0] dest;
    logic [7:0] a;
    logic [7:0] b;
    logic [7:0] aluOut;
    logic       aluCarry;
    src      = word[11:9];
    dest     = word[8:7];
    a        = model[0];
    b        = model[word[3:2]];
    aluCarry = 1'b0;
    case (word[14:12])
      3'd0: {aluCarry, aluOut} = {1'b0, a} + {1'b0, b};
      3'd1: begin
        aluOut   = a - b;
        aluCarry = a < b;
      end
      3'd2: aluOut = a & b;
      3'd3: aluOut = a | b;
      3'd4: aluOut = a ^ b;
      3'd5: aluOut = b;
      3'd6: begin
        aluOut   = {a[6:0], 1'b0};
        aluCarry = a[7];
      end
      default: aluOut = ~a;
    endcase
    expBus = model[0];
    if (valid && word[15]) begin
      expBus              = word[7:0];
      model[word[9:8]]    = word[7:0];
    end else if (valid && src != 3'd6 && src != 3'd7) begin
      if (src == 3'd4) begin
        expBus = aluOut;
      end else if (src == 3'd5) begin
        expBus = 8'h00;
      end else begin
        expBus = model[src[1:0]];
      end
      if (word[4]) begin
        model[dest] = 8'h00;
      end else if (word[6]) begin
        model[dest] = expBus;
      end else if (word[5]) begin
        model[dest] = model[dest] + 8'h01;
      end
      if (src == 3'd4 && word[6]) begin
        modelFlags = {aluOut == 8'h00, aluCarry};
      end
    end
    expFlags = modelFlags;
  endtask

  // drive on the falling edge, bus mid low phase, flags after the rise
  task automatic runCycle(input logic valid, input logic [15:0] word,
                          input logic [7:0] expBus, input logic [1:0] expFlags);
    waitClock(1'b0);
    microValid = valid;
    microIn    = word;
    #5;
    checkValue("busValue", {8'h00, busValue}, {8'h00, expBus});
    waitClock(1'b1);
    #5;
    checkValue("flags", {14'h0000, flags}, {14'h0000, expFlags});
  endtask

  initial begin
    logic [15:0] word;
    logic        valid;
    logic [7:0]  expBus;
    logic [1:0]  expFlags;
    clk        = 1'b0;
    reset      = 1'b1;
    microValid = 1'b0;
    microIn    = '0;
    lfsr       = 32'h6662bf12;
    modelFlags = 2'b00;
    for (int r = 0; r < 4; r++) begin
      model[r] = 8'h00;
    end
    buildTable();
    // four rising edges in reset
    repeat (4) begin
      waitClock(1'b1);
      waitClock(1'b0);
    end
    reset = 1'b0;
    foreach (rows[i]) begin
      modelStep(rows[i].valid, rows[i].word, expBus, expFlags);
      runCycle(rows[i].valid, rows[i].word, rows[i].bus, rows[i].flags);
    end
    // random phase, about half the transfers forced onto the alu
    for (int n = 0; n < 200; n++) begin
      valid = (takeBits(3) != 16'h0000);
      word  = takeBits(16);
      if (!word[15] && takeBits(1) == 16'h0001) begin
        word[11:9] = 3'd4;
      end
      modelStep(valid, word, expBus, expFlags);
      runCycle(valid, word, expBus, expFlags);
    end
    $display("PASS: all tests");
    $finish;
  end

endmodule

/* tb.f */
+incdir+.
busMachinePkg.sv
internalBus.sv
dataRegister.sv
aluUnit.sv
microDecoder.sv
busMachine.sv
tb_busMachine.sv

/* run.sh */
#!/bin/sh
# compile and run the testbench with verilator
cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator not found"
  exit 1
fi

verilator --binary --timing --assert -Wno-fatal --top-module tb_busMachine -f tb.f
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

output=$(./obj_dir/Vtb_busMachine)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "^PASS: all tests$"; then
  exit 0
fi
exit 1
